// ==== flist.f ====
+incdir+logic
logic/mem_resp_pkg.sv
logic/filter_cfg_pkg.sv
logic/sync_fifo.sv
logic/resp_accept.sv
logic/cfg_word_counter.sv
logic/cfg_load_fsm.sv
logic/cfg_field_decode.sv
logic/filter_cfg_loader.sv
bench/filter_cfg_loader_tb.sv

// ==== Bender.yml ====
package:
  name: filter_cfg_loader

sources:
  - include_dirs:
      - logic
    files:
      - logic/mem_resp_pkg.sv
      - logic/filter_cfg_pkg.sv
      - logic/sync_fifo.sv
      - logic/resp_accept.sv
      - logic/cfg_word_counter.sv
      - logic/cfg_load_fsm.sv
      - logic/cfg_field_decode.sv
      - logic/filter_cfg_loader.sv
  - target: test
    include_dirs:
      - logic
    files:
      - bench/filter_cfg_loader_tb.sv

// ==== bench/filter_cfg_loader_tb.sv ====
// Filter configuration loader testbench
`timescale 1ns/1ps
`default_nettype none

`include "filter_cfg_params.svh"

module filter_cfg_loader_tb;

    import mem_resp_pkg::*;
    import filter_cfg_pkg::*;

    localparam int wait_limit = 2000;
    localparam logic [`CLASS_W-1:0] class_other = 4'd7;

    typedef logic [`FIELD_W-1:0] seq_words_t [`SEQ_SLOTS];

    logic            ap_clk;
    logic            arst_n;
    logic            run;
    logic            cfg_rd_en;
    mem_resp_t       resp_in;
    filter_cfg_out_t cfg_out;
    fifo_status_t    resp_status;
    fifo_status_t    cfg_status;

    logic [31:0]     rng_state;
    filter_cfg_t     exp_q [$];
    int              err_count;
    int              err_at_start;
    int              rx_count;
    int              tests_passed;
    int              tests_failed;

    filter_cfg_loader i_filter_cfg_loader (
        .ap_clk     (ap_clk),
        .arst_n     (arst_n),
        .resp_in    (resp_in),
        .run        (run),
        .cfg_rd_en  (cfg_rd_en),
        .cfg_out    (cfg_out),
        .resp_status(resp_status),
        .cfg_status (cfg_status)
    );

    initial begin
        ap_clk = 1'b0;
        forever #5 ap_clk = ~ap_clk;
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic seq_words_t random_words();
        seq_words_t w;
        for (int i = 0; i < `SEQ_SLOTS; i++) begin
            w[i] = next_rand();
        end
        return w;
    endfunction

    // Expected configuration from words 0 to 5
    function automatic filter_cfg_t ref_decode(input seq_words_t w);
        filter_cfg_t r;
        r = '0;
        r.filter_op                = filter_op_t'(w[0][3:0]);
        r.filter_mask              = w[1][3:0];
        r.const_mask               = w[2][3:0];
        r.const_value              = w[3];
        r.ops_mask                 = w[4][15:0];
        r.flags.break_flag         = w[5][0];
        r.flags.break_pass         = w[5][1];
        r.flags.filter_post        = w[5][2];
        r.flags.filter_pass        = w[5][3];
        r.flags.continue_flag      = w[5][4];
        r.flags.ternary_flag       = w[5][5];
        r.flags.conditional_flag   = w[5][6];
        return r;
    endfunction

    task automatic step();
        @(posedge ap_clk);
        #1;
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("** FAIL **");
        $finish;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got === want) else begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, want);
            err_count++;
        end
    endtask

    task automatic begin_test();
        err_at_start = err_count;
    endtask

    task automatic end_test(input string name);
        if (err_count == err_at_start) begin
            tests_passed++;
            $display("Test %s: passed", name);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, err_count - err_at_start);
        end
    endtask

    // One word per three cycles, so the full flag is current when checked
    task automatic send_word(input logic [`CLASS_W-1:0] cls, input int seq,
                             input int shift, input logic [`FIELD_W-1:0] data);
        int cycles;
        cycles = 0;
        while (resp_status.full && cycles < wait_limit) begin
            step();
            cycles++;
        end
        if (resp_status.full) begin
            abort_on_timeout("room in the response FIFO");
        end else begin
            resp_in.valid             = 1'b1;
            resp_in.payload.buf_class = cls;
            resp_in.payload.shift     = `SHIFT_W'(shift);
            resp_in.payload.offset    = `OFFSET_W'(seq << shift);
            resp_in.payload.data      = data;
            step();
            resp_in.valid = 1'b0;
            step();
            step();
        end
    endtask

    // Setup word for slot idx with a random class and shift
    task automatic send_valid_word(input int idx, input logic [`FIELD_W-1:0] data);
        logic [31:0] r;
        r = next_rand();
        send_word(r[28] ? `CLASS_CU_SETUP : `CLASS_ENGINE_SETUP, `SEQ_BASE + idx,
                  (r >> 24) % 3, data);
    endtask

    task automatic read_configs(input int n);
        int cycles;
        for (int k = 0; k < n; k++) begin
            cycles = 0;
            while (cfg_status.empty && cycles < wait_limit) begin
                step();
                cycles++;
            end
            if (cfg_status.empty) begin
                abort_on_timeout("a configuration in the output FIFO");
            end else begin
                cfg_rd_en = 1'b1;
                step();
                cfg_rd_en = 1'b0;
            end
        end
    endtask

    task automatic wait_received(input int target);
        int cycles;
        cycles = 0;
        while (rx_count < target && cycles < wait_limit) begin
            step();
            cycles++;
        end
        if (rx_count < target) begin
            abort_on_timeout("cfg_out.valid");
        end
    endtask

    // ------------------------------
    // Output compare
    // ------------------------------
    initial begin
        filter_cfg_t want;
        forever begin
            @(negedge ap_clk);
            if (arst_n && cfg_out.valid) begin
                assert (exp_q.size() > 0) else begin
                    $display("A configuration arrived at %0t with none expected", $time);
                    err_count++;
                end
                if (exp_q.size() > 0) begin
                    want = exp_q.pop_front();
                    check_value("filter_op", 32'(cfg_out.cfg.filter_op), 32'(want.filter_op));
                    check_value("filter_mask", 32'(cfg_out.cfg.filter_mask),
                                32'(want.filter_mask));
                    check_value("const_mask", 32'(cfg_out.cfg.const_mask),
                                32'(want.const_mask));
                    check_value("const_value", cfg_out.cfg.const_value, want.const_value);
                    check_value("ops_mask", 32'(cfg_out.cfg.ops_mask), 32'(want.ops_mask));
                    check_value("flags", 32'(cfg_out.cfg.flags), 32'(want.flags));
                end
                rx_count++;
            end
        end
    end

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        seq_words_t words;
        int         base;
        int         cycles;
        rng_state    = 32'h6c3be807;
        err_count    = 0;
        err_at_start = 0;
        rx_count     = 0;
        tests_passed = 0;
        tests_failed = 0;
        resp_in      = '0;
        run          = 1'b0;
        cfg_rd_en    = 1'b0;
        arst_n       = 1'b0;
        repeat (2) @(posedge ap_clk);
        #1;
        arst_n = 1'b1;

        begin_test();
        check_value("cfg_out.valid", 32'(cfg_out.valid), 0);
        check_value("resp_status.empty", 32'(resp_status.empty), 1);
        check_value("cfg_status.empty", 32'(cfg_status.empty), 1);
        check_value("resp_status.full", 32'(resp_status.full), 0);
        check_value("cfg_status.full", 32'(cfg_status.full), 0);
        check_value("resp_status.prog_full", 32'(resp_status.prog_full), 0);
        check_value("cfg_status.prog_full", 32'(cfg_status.prog_full), 0);
        end_test("reset state");

        begin_test();
        run   = 1'b1;
        base  = rx_count;
        words = random_words();
        exp_q.push_back(ref_decode(words));
        for (int i = 0; i < `SEQ_SLOTS; i++) begin
            send_valid_word(i, words[i]);
        end
        read_configs(1);
        wait_received(base + 1);
        end_test("full sequence decode");

        // Foreign class at the base slot would restart the count if taken
        begin_test();
        base  = rx_count;
        words = random_words();
        exp_q.push_back(ref_decode(words));
        for (int i = 0; i < `SEQ_SLOTS; i++) begin
            send_valid_word(i, words[i]);
            if (i % 4 == 1) begin
                send_word(class_other, `SEQ_BASE, 0, next_rand());
            end
            if (i % 4 == 3) begin
                send_word(`CLASS_CU_SETUP, `SEQ_BASE + `SEQ_SLOTS + i, 1, next_rand());
                send_word(`CLASS_ENGINE_SETUP, `SEQ_BASE - 1 - i, 0, next_rand());
            end
        end
        read_configs(1);
        wait_received(base + 1);
        repeat (40) step();
        check_value("configurations received", 32'(rx_count - base), 1);
        end_test("rejection");

        begin_test();
        base = rx_count;
        for (int i = 0; i < 7; i++) begin
            send_valid_word(i, next_rand());
        end
        words = random_words();
        exp_q.push_back(ref_decode(words));
        for (int i = 0; i < `SEQ_SLOTS; i++) begin
            send_valid_word(i, words[i]);
        end
        read_configs(1);
        wait_received(base + 1);
        repeat (40) step();
        check_value("configurations received", 32'(rx_count - base), 1);
        check_value("cfg_status.empty", 32'(cfg_status.empty), 1);
        end_test("restart");

        // Sender blocks on a full response FIFO until reads free the stall
        begin_test();
        base = rx_count;
        fork
            begin
                for (int s = 0; s < 5; s++) begin
                    words = random_words();
                    exp_q.push_back(ref_decode(words));
                    for (int i = 0; i < `SEQ_SLOTS; i++) begin
                        send_valid_word(i, words[i]);
                    end
                end
            end
            begin
                cycles = 0;
                while (!(cfg_status.prog_full && !resp_status.empty) &&
                       cycles < wait_limit) begin
                    step();
                    cycles++;
                end
                if (!(cfg_status.prog_full && !resp_status.empty)) begin
                    abort_on_timeout("the loader to stall");
                end else begin
                    repeat (10) step();
                    check_value("cfg_status.prog_full", 32'(cfg_status.prog_full), 1);
                    check_value("resp_status.empty", 32'(resp_status.empty), 0);
                    check_value("configurations received", 32'(rx_count - base), 0);
                    cycles = 0;
                    while (!resp_status.full && cycles < wait_limit) begin
                        step();
                        cycles++;
                    end
                    if (!resp_status.full) begin
                        abort_on_timeout("the response FIFO to fill");
                    end else begin
                        // Loader holds the output FIFO at its threshold
                        check_value("cfg_status.full", 32'(cfg_status.full), 0);
                        check_value("cfg_status.prog_full", 32'(cfg_status.prog_full), 1);
                        check_value("configurations received", 32'(rx_count - base), 0);
                        read_configs(5);
                    end
                end
            end
        join
        wait_received(base + 5);
        repeat (40) step();
        check_value("configurations received", 32'(rx_count - base), 5);
        end_test("back-pressure and ordering");

        begin_test();
        run   = 1'b0;
        base  = rx_count;
        words = random_words();
        exp_q.push_back(ref_decode(words));
        for (int i = 0; i < `SEQ_SLOTS; i++) begin
            send_valid_word(i, words[i]);
        end
        repeat (20) step();
        check_value("configurations received", 32'(rx_count - base), 0);
        check_value("resp_status.empty", 32'(resp_status.empty), 0);
        check_value("cfg_status.empty", 32'(cfg_status.empty), 1);
        run = 1'b1;
        read_configs(1);
        wait_received(base + 1);
        end_test("run gating");

        $display("Tests passed %0d, failed %0d, errors %0d",
                 tests_passed, tests_failed, err_count);
        if (err_count == 0 && exp_q.size() == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/filter_cfg_loader.sv ====
// Filter configuration loader top
`timescale 1ns/1ps
`default_nettype none

`include "filter_cfg_params.svh"

module filter_cfg_loader (
    input  logic                             ap_clk,
    input  logic                             arst_n,
    input  mem_resp_pkg::mem_resp_t          resp_in,
    input  logic                             run,
    input  logic                             cfg_rd_en,
    output filter_cfg_pkg::filter_cfg_out_t  cfg_out,
    output filter_cfg_pkg::fifo_status_t     resp_status,
    output filter_cfg_pkg::fifo_status_t     cfg_status
);

    import mem_resp_pkg::*;
    import filter_cfg_pkg::*;

    localparam int pos_w = $clog2(`SEQ_SLOTS);

    // ------------------------------
    // Response path
    // ------------------------------
    cfg_word_t        acc_word;
    logic             acc_wr_en;
    cfg_word_t        resp_dout;
    logic             resp_valid;
    logic             resp_pop;
    logic [pos_w-1:0] word_pos;
    logic             last_word;

    // ------------------------------
    // Configuration path
    // ------------------------------
    filter_cfg_t      cfg_reg;
    logic             cfg_wr_en;
    logic             cfg_pop;
    filter_cfg_t      cfg_dout;
    logic             cfg_valid;
    logic             out_valid;
    filter_cfg_t      out_cfg;

    resp_accept i_resp_accept (
        .ap_clk (ap_clk),
        .arst_n (arst_n),
        .resp_in(resp_in),
        .wr_en  (acc_wr_en),
        .word   (acc_word)
    );

    sync_fifo #(
        .payload_t  (cfg_word_t),
        .depth      (`RESP_FIFO_DEPTH),
        .prog_thresh(`RESP_FIFO_DEPTH)
    ) i_resp_fifo (
        .ap_clk(ap_clk),
        .arst_n(arst_n),
        .wr_en (acc_wr_en),
        .din   (acc_word),
        .rd_en (resp_pop),
        .dout  (resp_dout),
        .valid (resp_valid),
        .status(resp_status)
    );

    cfg_word_counter i_cfg_word_counter (
        .ap_clk    (ap_clk),
        .arst_n    (arst_n),
        .word_valid(resp_valid),
        .first     (resp_dout.first),
        .position  (word_pos),
        .last      (last_word)
    );

    cfg_load_fsm i_cfg_load_fsm (
        .ap_clk       (ap_clk),
        .arst_n       (arst_n),
        .run          (run),
        .resp_empty   (resp_status.empty),
        .cfg_prog_full(cfg_status.prog_full),
        .last         (last_word),
        .pop          (resp_pop),
        .cfg_wr_en    (cfg_wr_en)
    );

    cfg_field_decode i_cfg_field_decode (
        .ap_clk    (ap_clk),
        .arst_n    (arst_n),
        .word_valid(resp_valid),
        .position  (word_pos),
        .data      (resp_dout.data),
        .cfg       (cfg_reg)
    );

    // Read strobes on an empty FIFO are ignored
    assign cfg_pop = cfg_rd_en && !cfg_status.empty;

    sync_fifo #(
        .payload_t  (filter_cfg_t),
        .depth      (`CFG_FIFO_DEPTH),
        .prog_thresh(`CFG_PROG_THRESH)
    ) i_cfg_fifo (
        .ap_clk(ap_clk),
        .arst_n(arst_n),
        .wr_en (cfg_wr_en),
        .din   (cfg_reg),
        .rd_en (cfg_pop),
        .dout  (cfg_dout),
        .valid (cfg_valid),
        .status(cfg_status)
    );

    // ------------------------------
    // Output register
    // ------------------------------
    always_ff @(posedge ap_clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= cfg_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        out_cfg <= cfg_dout;
    end

    assign cfg_out = '{valid: out_valid, cfg: out_cfg};

endmodule

`default_nettype wire

// ==== logic/cfg_field_decode.sv ====
// Configuration field decoder
`timescale 1ns/1ps
`default_nettype none

`include "filter_cfg_params.svh"

module cfg_field_decode (
    input  logic                          ap_clk,
    input  logic                          arst_n,
    input  logic                          word_valid,
    input  logic [$clog2(`SEQ_SLOTS)-1:0] position,
    input  logic [`FIELD_W-1:0]           data,
    output filter_cfg_pkg::filter_cfg_t   cfg
);

    import filter_cfg_pkg::*;

    // ------------------------------
    // Field register
    // ------------------------------
    // Words 6 and up are counted but carry nothing for this engine
    always_ff @(posedge ap_clk or negedge arst_n) begin
        if (!arst_n) begin
            cfg <= '0;
        end else if (word_valid) begin
            case (position)
                0: begin
                    cfg.filter_op <= filter_op_t'(data[`FILTER_OP_W-1:0]);
                end
                1: begin
                    cfg.filter_mask <= data[`NUM_FIELDS-1:0];
                end
                2: begin
                    cfg.const_mask <= data[`NUM_FIELDS-1:0];
                end
                3: begin
                    cfg.const_value <= data;
                end
                4: begin
                    cfg.ops_mask <= data[`NUM_FIELDS*`NUM_FIELDS-1:0];
                end
                // Flag word, one bit each
                5: begin
                    cfg.flags.break_flag       <= data[0];
                    cfg.flags.break_pass       <= data[1];
                    cfg.flags.filter_post      <= data[2];
                    cfg.flags.filter_pass      <= data[3];
                    cfg.flags.continue_flag    <= data[4];
                    cfg.flags.ternary_flag     <= data[5];
                    cfg.flags.conditional_flag <= data[6];
                end
                default: begin
                    cfg <= cfg;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/cfg_load_fsm.sv ====
// Configuration loader FSM
`timescale 1ns/1ps
`default_nettype none

module cfg_load_fsm (
    input  logic ap_clk,
    input  logic arst_n,
    input  logic run,
    input  logic resp_empty,
    input  logic cfg_prog_full,
    input  logic last,
    output logic pop,
    output logic cfg_wr_en
);

    import filter_cfg_pkg::*;

    load_state_t state;
    load_state_t state_nxt;

    // ------------------------------
    // Pop gating
    // ------------------------------
    // One word in flight at a time, so last is known before the next pop
    // and no new word reaches the decoder before the emit write
    assign pop = (state == LOAD_IDLE) && !last && !resp_empty && run && !cfg_prog_full;

    // Single write of the finished configuration
    assign cfg_wr_en = (state == LOAD_EMIT);

    // ------------------------------
    // State transitions
    // ------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            LOAD_IDLE: begin
                if (last) begin
                    state_nxt = LOAD_EMIT;
                end else if (pop) begin
                    state_nxt = LOAD_COLLECT;
                end
            end
            // Popped word is on its way to the counter
            LOAD_COLLECT: begin
                state_nxt = LOAD_IDLE;
            end
            LOAD_EMIT: begin
                state_nxt = LOAD_IDLE;
            end
            default: begin
                state_nxt = LOAD_IDLE;
            end
        endcase
    end

    always_ff @(posedge ap_clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= LOAD_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== logic/cfg_word_counter.sv ====
// Configuration word position counter
`timescale 1ns/1ps
`default_nettype none

`include "filter_cfg_params.svh"

module cfg_word_counter (
    input  logic                          ap_clk,
    input  logic                          arst_n,
    input  logic                          word_valid,
    input  logic                          first,
    output logic [$clog2(`SEQ_SLOTS)-1:0] position,
    output logic                          last
);

    localparam int pos_w = $clog2(`SEQ_SLOTS);

    // Position of the previous word
    logic [pos_w-1:0] pos_q;

    // Slot of the word now at the FIFO output
    assign position = first ? '0 : pos_q + 1'b1;

    always_ff @(posedge ap_clk or negedge arst_n) begin
        if (!arst_n) begin
            // All ones so an unflagged word after reset lands on slot 0
            pos_q <= '1;
            last  <= 1'b0;
        end else begin
            last <= word_valid && (position == pos_w'(`SEQ_SLOTS - 1));
            if (word_valid) begin
                pos_q <= position;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/resp_accept.sv ====
// Response word acceptance filter
`timescale 1ns/1ps
`default_nettype none

`include "filter_cfg_params.svh"

module resp_accept (
    input  logic                   ap_clk,
    input  logic                   arst_n,
    input  mem_resp_pkg::mem_resp_t resp_in,
    output logic                   wr_en,
    output mem_resp_pkg::cfg_word_t word
);

    import mem_resp_pkg::*;

    logic                 resp_valid_q;
    mem_resp_payload_t    resp_q;
    logic [`OFFSET_W-1:0] seq;
    logic                 class_ok;
    logic                 window_ok;

    // Input register
    always_ff @(posedge ap_clk or negedge arst_n) begin
        if (!arst_n) begin
            resp_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= resp_in.valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        resp_q <= resp_in.payload;
    end

    // Sequence number of the registered word
    assign seq = resp_q.offset >> resp_q.shift;

    assign class_ok  = (resp_q.buf_class == `CLASS_CU_SETUP) ||
                       (resp_q.buf_class == `CLASS_ENGINE_SETUP);
    assign window_ok = (seq >= `SEQ_BASE) && (seq < `SEQ_BASE + `SEQ_SLOTS);

    assign wr_en = resp_valid_q && class_ok && window_ok;

    always_comb begin
        word.first = (seq == `SEQ_BASE);
        word.data  = resp_q.data;
    end

endmodule

`default_nettype wire

// ==== logic/sync_fifo.sv ====
// Synchronous FIFO
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter type payload_t   = logic,
    parameter int  depth       = 16,
    parameter int  prog_thresh = 8
) (
    input  logic                        ap_clk,
    input  logic                        arst_n,
    input  logic                        wr_en,
    input  payload_t                    din,
    input  logic                        rd_en,
    output payload_t                    dout,
    output logic                        valid,
    output filter_cfg_pkg::fifo_status_t status
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t         mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_wr;
    logic             do_rd;

    // Wraps at depth, so depth need not be a power of two
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Writes into a full FIFO are dropped
    assign do_wr = wr_en && !status.full;
    assign do_rd = rd_en && !status.empty;

    always_comb begin
        status.full      = (count == cnt_w'(depth));
        status.empty     = (count == '0);
        status.prog_full = (count >= cnt_w'(prog_thresh));
    end

    // ------------------------------
    // Storage
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (do_rd) begin
            dout <= mem[rd_ptr];
        end
    end

    // ------------------------------
    // Pointers and fill count
    // ------------------------------
    always_ff @(posedge ap_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            valid  <= 1'b0;
        end else begin
            valid <= do_rd;
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_wr, do_rd})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/filter_cfg_pkg.sv ====
// Filter configuration types
`default_nettype none

`include "filter_cfg_params.svh"

package filter_cfg_pkg;

    // ------------------------------
    // Filter configuration
    // ------------------------------

    typedef enum logic [`FILTER_OP_W-1:0] {
        FILTER_NOP,
        FILTER_GT,
        FILTER_LT,
        FILTER_EQ,
        FILTER_NE,
        FILTER_GE,
        FILTER_LE,
        FILTER_AND,
        FILTER_OR,
        FILTER_XOR,
        FILTER_NOT,
        FILTER_GT_TERN,
        FILTER_LT_TERN,
        FILTER_EQ_TERN,
        FILTER_NE_TERN,
        FILTER_PASS_ALL
    } filter_op_t;

    typedef struct packed {
        logic break_flag;
        logic break_pass;
        logic filter_post;
        logic filter_pass;
        logic continue_flag;
        logic ternary_flag;
        logic conditional_flag;
    } filter_flags_t;

    typedef struct packed {
        filter_op_t                           filter_op;
        logic [`NUM_FIELDS-1:0]               filter_mask;
        logic [`NUM_FIELDS-1:0]               const_mask;
        logic [`FIELD_W-1:0]                  const_value;
        logic [`NUM_FIELDS*`NUM_FIELDS-1:0]   ops_mask;
        filter_flags_t                        flags;
    } filter_cfg_t;

    typedef struct packed {
        logic        valid;
        filter_cfg_t cfg;
    } filter_cfg_out_t;

    // ------------------------------
    // FIFO and loader state
    // ------------------------------

    typedef struct packed {
        logic full;
        logic empty;
        logic prog_full;
    } fifo_status_t;

    typedef enum logic [1:0] {
        LOAD_IDLE,
        LOAD_COLLECT,
        LOAD_EMIT
    } load_state_t;

endpackage

`default_nettype wire

// ==== logic/mem_resp_pkg.sv ====
// Memory response word types
`default_nettype none

`include "filter_cfg_params.svh"

package mem_resp_pkg;

    // ------------------------------
    // Incoming response word
    // ------------------------------

    // Class, address offset, shift amount and one data field
    typedef struct packed {
        logic [`CLASS_W-1:0]  buf_class;
        logic [`OFFSET_W-1:0] offset;
        logic [`SHIFT_W-1:0]  shift;
        logic [`FIELD_W-1:0]  data;
    } mem_resp_payload_t;

    typedef struct packed {
        logic              valid;
        mem_resp_payload_t payload;
    } mem_resp_t;

    // ------------------------------
    // Accepted word
    // ------------------------------

    // Response FIFO entry, first marks the window base
    typedef struct packed {
        logic                first;
        logic [`FIELD_W-1:0] data;
    } cfg_word_t;

endpackage

`default_nettype wire

// ==== logic/filter_cfg_params.svh ====
// Filter configuration loader parameters
`ifndef FILTER_CFG_PARAMS_SVH
`define FILTER_CFG_PARAMS_SVH

// ------------------------------
// Data word
// ------------------------------
`define FIELD_W             32
`define NUM_FIELDS          4
`define FILTER_OP_W         4

// ------------------------------
// Sequence window
// ------------------------------
`define SEQ_SLOTS           16
`define SEQ_BASE            32
`define OFFSET_W            16
`define SHIFT_W             4

// Buffer classes accepted as setup words
`define CLASS_W             4
`define CLASS_CU_SETUP      4'd3
`define CLASS_ENGINE_SETUP  4'd4

// ------------------------------
// FIFO sizing
// ------------------------------
`define RESP_FIFO_DEPTH     16
`define CFG_FIFO_DEPTH      4
`define CFG_PROG_THRESH     3

`endif
